// File: vlog.f
hw/vio_switch_pkg.sv
hw/switch_cfg_regs.sv
hw/route_decoder.sv
hw/dest_arbiter.sv
hw/out_reg_slice.sv
hw/vio_switch.sv
verification/vio_switch_props.sv
verification/tb_vio_switch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= tb_vio_switch
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_vio_switch.sv
// Testbench for the packet switch
// Clock and reset, LFSR stimulus, reference model with per-destination
// queues, directed tests for routing, contention, drops and back-pressure

`timescale 1ns/10ps
`default_nettype none

module tb_vio_switch;
  import vio_switch_pkg::*;

  localparam int N_ID      = 3;
  localparam int N_PORTS   = N_ID + N_SERVICE;
  localparam int PORT_W    = $clog2(N_PORTS);
  localparam int MAX_CYCLE = 4000;
  localparam int TCP       = N_ID + PORT_TCP;
  localparam int RDMA_RX   = N_ID + PORT_RDMA_RX;

  logic                       aclk;
  logic                       arst_n;
  logic [N_PORTS-1:0]         src_valid;
  logic [N_PORTS-1:0]         src_ready;
  axis_beat_t [N_PORTS-1:0]   src_beat;
  logic [N_PORTS-1:0]         dst_valid;
  logic [N_PORTS-1:0]         dst_ready;
  axis_beat_t [N_PORTS-1:0]   dst_beat;
  logic [N_PORTS-1:0]         decode_err;
  logic                       cfg_wr;
  logic [PORT_W-1:0]          cfg_src;
  logic [N_PORTS-1:0]         cfg_mask;

  // Reference model state
  axis_beat_t         exp_q[N_PORTS][$];
  pid_t               tcp_log[$];
  logic [N_PORTS-1:0] mask_m[N_PORTS];
  logic               in_pkt_m[N_PORTS];
  logic               drop_m[N_PORTS];
  int                 delivered;

  string       test_name;
  int          beat_errs;
  int          err_errs;
  int          other_errs;
  int          cycles;
  logic        bp_en;
  logic [15:0] lfsr;

  vio_switch #(.N_ID(N_ID)) i_vio_switch (
    .aclk(aclk), .arst_n(arst_n),
    .src_valid(src_valid), .src_ready(src_ready), .src_beat(src_beat),
    .dst_valid(dst_valid), .dst_ready(dst_ready), .dst_beat(dst_beat),
    .decode_err(decode_err),
    .cfg_wr(cfg_wr), .cfg_src(cfg_src), .cfg_mask(cfg_mask)
  );

  bind vio_switch vio_switch_props #(.N_ID(N_ID)) i_props (
    .aclk(aclk), .arst_n(arst_n), .src_valid(src_valid), .src_ready(src_ready),
    .dst_valid(dst_valid), .dst_ready(dst_ready), .dst_beat(dst_beat),
    .decode_err(decode_err)
  );

  always #5 aclk = ~aclk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 16'hB400;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      beat_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      err_errs++;
    end
  endtask

  always @(negedge aclk) begin
    if (bp_en) begin
      dst_ready <= N_PORTS'(lfsr_bits(N_PORTS));
    end else begin
      dst_ready <= '1;
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= MAX_CYCLE) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLE);
      $display("Regression failed");
      $finish;
    end
  end

  // Source transfers fill the queues and destination transfers drain them
  always @(posedge aclk) begin
    axis_beat_t b;
    if (arst_n) begin
      for (int s = 0; s < N_PORTS; s++) begin
        if (src_valid[s] && src_ready[s]) begin
          b = src_beat[s];
          if (!in_pkt_m[s]) begin
            drop_m[s] = (b.dest >= N_PORTS) || !mask_m[s][b.dest[PORT_W-1:0]];
            check_err(test_name, drop_m[s], decode_err[s]);
          end else begin
            check_err(test_name, 1'b0, decode_err[s]);
          end
          if (!drop_m[s]) begin
            exp_q[b.dest[PORT_W-1:0]].push_back(b);
          end
          in_pkt_m[s] = !b.last;
        end
      end
      for (int d = 0; d < N_PORTS; d++) begin
        if (dst_valid[d] && dst_ready[d]) begin
          delivered++;
          if (d == TCP) begin
            tcp_log.push_back(dst_beat[d].id);
          end
          if (exp_q[d].size() == 0) begin
            $display("%s: beat appeared at destination %0d with nothing sent to it",
                     test_name, d);
            other_errs++;
          end else begin
            check_beat(test_name, exp_q[d].pop_front(), dst_beat[d]);
          end
        end
      end
      // A write affects packets that start after this edge
      if (cfg_wr) begin
        mask_m[cfg_src] = cfg_mask;
      end
    end
  end

  task automatic apply_reset();
    arst_n = 1'b0;
    for (int p = 0; p < N_PORTS; p++) begin
      mask_m[p]   = '1;
      in_pkt_m[p] = 1'b0;
      drop_m[p]   = 1'b0;
      exp_q[p].delete();
    end
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
  endtask

  // Called and returns on a falling edge
  task automatic send_pkt(input int s, input int dest, input int len, input int gap,
                          output int stalls);
    axis_beat_t b;
    stalls = 0;
    for (int i = 0; i < len; i++) begin
      if (gap > 0) begin
        src_valid[s] = 1'b0;
        repeat (gap) @(negedge aclk);
      end
      b.data = {lfsr_bits(32), lfsr_bits(32)};
      b.keep = keep_t'(lfsr_bits(KEEP_BITS));
      b.last = (i == len - 1);
      b.id   = pid_t'((s << 3) | (i & 7));
      b.dest = dest_t'(dest);
      src_beat[s]  = b;
      src_valid[s] = 1'b1;
      @(posedge aclk);
      while (!src_ready[s]) begin
        stalls++;
        @(posedge aclk);
      end
      @(negedge aclk);
    end
    src_valid[s] = 1'b0;
  endtask

  task automatic write_mask(input int s, input logic [N_PORTS-1:0] mask);
    cfg_wr   = 1'b1;
    cfg_src  = PORT_W'(s);
    cfg_mask = mask;
    @(negedge aclk);
    cfg_wr = 1'b0;
  endtask

  task automatic wait_drain();
    int pending;
    do begin
      @(negedge aclk);
      pending = 0;
      for (int d = 0; d < N_PORTS; d++) begin
        pending += exp_q[d].size();
      end
    end while (pending > 0);
    repeat (3) @(negedge aclk);
  endtask

  task automatic contend_for_tcp();
    int st1;
    int st4;
    test_name = "contention";
    tcp_log.delete();
    fork
      send_pkt(1, TCP, 4, 0, st1);
      send_pkt(4, TCP, 4, 0, st4);
    join
    wait_drain();
    if (tcp_log.size() != 8) begin
      $display("%s: %0d beats reached TCP instead of 8", test_name, tcp_log.size());
      other_errs++;
    end else begin
      for (int i = 0; i < 8; i++) begin
        check_err(test_name, 1'b1, tcp_log[i][5:3] == ((i < 4) ? 3'd1 : 3'd4));
      end
    end
  endtask

  task automatic route_source(input int s);
    int st;
    for (int d = 0; d < N_PORTS; d++) begin
      send_pkt(s, d, 3, 0, st);
    end
  endtask

  task automatic route_all_pairs();
    test_name = "routing";
    for (int s = 0; s < N_PORTS; s++) begin
      fork
        automatic int ss = s;
        route_source(ss);
      join_none
    end
    wait fork;
    wait_drain();
  endtask

  task automatic drop_bad_dest();
    int st;
    int start;
    test_name = "bad_dest";
    start = delivered;
    send_pkt(2, 9, 3, 0, st);
    check_err(test_name, 1'b0, st != 0);
    send_pkt(5, 16383, 2, 0, st);
    check_err(test_name, 1'b0, st != 0);
    wait_drain();
    if (delivered != start) begin
      $display("%s: a dropped packet reached a destination", test_name);
      other_errs++;
    end
  endtask

  task automatic toggle_connectivity();
    int st;
    test_name = "connectivity";
    write_mask(0, ~(N_PORTS'(1) << RDMA_RX));
    send_pkt(0, RDMA_RX, 3, 0, st);
    send_pkt(1, RDMA_RX, 3, 0, st);
    write_mask(0, '1);
    send_pkt(0, RDMA_RX, 3, 0, st);
    wait_drain();
  endtask

  task automatic random_source(input int s, inout int beats);
    int st;
    int len;
    while (beats < 29) begin
      len = 1 + int'(lfsr_bits(2));
      send_pkt(s, int'(lfsr_bits(3)) % N_PORTS, len, int'(lfsr_bits(2)) % 3, st);
      beats += len;
    end
  endtask

  task automatic stress_backpressure();
    int beats[N_PORTS];
    int total;
    int start;
    test_name = "backpressure";
    start = delivered;
    bp_en = 1'b1;
    for (int s = 0; s < N_PORTS; s++) begin
      beats[s] = 0;
      fork
        automatic int ss = s;
        random_source(ss, beats[ss]);
      join_none
    end
    wait fork;
    wait_drain();
    bp_en = 1'b0;
    total = 0;
    for (int s = 0; s < N_PORTS; s++) begin
      total += beats[s];
    end
    if (total < 200 || delivered - start != total) begin
      $display("%s: sent %0d beats but %0d were delivered", test_name, total,
               delivered - start);
      other_errs++;
    end
  endtask

  initial begin
    aclk       = 1'b0;
    arst_n     = 1'b0;
    src_valid  = '0;
    src_beat   = '0;
    dst_ready  = '1;
    cfg_wr     = 1'b0;
    cfg_src    = '0;
    cfg_mask   = '0;
    bp_en      = 1'b0;
    lfsr       = 16'd69;
    beat_errs  = 0;
    err_errs   = 0;
    other_errs = 0;
    cycles     = 0;
    delivered  = 0;
    test_name  = "reset";
    @(negedge aclk);
    apply_reset();
    // Round-robin start position only holds right after reset
    contend_for_tcp();
    route_all_pairs();
    drop_bad_dest();
    toggle_connectivity();
    stress_backpressure();
    $display("Errors: beat %0d, decode_err %0d, other %0d", beat_errs, err_errs, other_errs);
    if (beat_errs + err_errs + other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/vio_switch_props.sv
// Concurrent checks on the stream ports of the switch
// Destination hold rule, decode errors tied to transfers, reset state

`timescale 1ns/10ps
`default_nettype none

module vio_switch_props #(
  parameter int N_ID = 3,
  localparam int N_PORTS = N_ID + vio_switch_pkg::N_SERVICE
) (
  input wire logic                                      aclk,
  input wire logic                                      arst_n,
  input wire logic [N_PORTS-1:0]                        src_valid,
  input wire logic [N_PORTS-1:0]                        src_ready,
  input wire logic [N_PORTS-1:0]                        dst_valid,
  input wire logic [N_PORTS-1:0]                        dst_ready,
  input wire vio_switch_pkg::axis_beat_t [N_PORTS-1:0]  dst_beat,
  input wire logic [N_PORTS-1:0]                        decode_err
);

  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    // A stalled beat must wait unchanged
    a_dst_hold: assert property (@(posedge aclk) disable iff (!arst_n)
      dst_valid[p] && !dst_ready[p] |=> dst_valid[p] && $stable(dst_beat[p]))
      else $error("destination %0d dropped or changed a stalled beat", p);

    a_err_xfer: assert property (@(posedge aclk) disable iff (!arst_n)
      decode_err[p] |-> src_valid[p] && src_ready[p])
      else $error("decode_err on source %0d without a transfer", p);
  end

  a_reset_idle: assert property (@(posedge aclk) !arst_n |-> dst_valid == '0)
    else $error("dst_valid high during reset");

endmodule

`default_nettype wire

// File: hw/vio_switch.sv
// Top level of the region and service packet switch
// Config registers, one decoder per source, one arbiter and
// output slice per destination

`timescale 1ns/10ps
`default_nettype none

module vio_switch #(
  parameter int N_ID = 3,
  localparam int N_PORTS = N_ID + vio_switch_pkg::N_SERVICE,
  localparam int PORT_W = $clog2(N_PORTS)
) (
  input  logic                                      aclk,
  input  logic                                      arst_n,

  // Sources into the switch
  input  logic [N_PORTS-1:0]                        src_valid,
  output logic [N_PORTS-1:0]                        src_ready,
  input  vio_switch_pkg::axis_beat_t [N_PORTS-1:0]  src_beat,

  // Destinations out of the switch
  output logic [N_PORTS-1:0]                        dst_valid,
  input  logic [N_PORTS-1:0]                        dst_ready,
  output vio_switch_pkg::axis_beat_t [N_PORTS-1:0]  dst_beat,

  output logic [N_PORTS-1:0]                        decode_err,

  // Connectivity writes
  input  logic                                      cfg_wr,
  input  logic [PORT_W-1:0]                         cfg_src,
  input  logic [N_PORTS-1:0]                        cfg_mask
);
  import vio_switch_pkg::*;

  logic [N_PORTS-1:0][N_PORTS-1:0] conn_mask;
  // Indexed [source][destination]
  logic [N_PORTS-1:0][N_PORTS-1:0] req_src;
  logic [N_PORTS-1:0][N_PORTS-1:0] acc_src;
  // Indexed [destination][source]
  logic [N_PORTS-1:0][N_PORTS-1:0] req_dst;
  logic [N_PORTS-1:0][N_PORTS-1:0] acc_dst;

  logic [N_PORTS-1:0]              arb_valid;
  axis_beat_t [N_PORTS-1:0]        arb_beat;
  logic [N_PORTS-1:0]              slice_ready;

  switch_cfg_regs #(.N_ID(N_ID)) i_cfg_regs (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_src   (cfg_src),
    .cfg_mask  (cfg_mask),
    .conn_mask (conn_mask)
  );

  for (genvar s = 0; s < N_PORTS; s++) begin : g_src
    route_decoder #(.N_ID(N_ID)) i_route_decoder (
      .aclk       (aclk),
      .arst_n     (arst_n),
      .src_valid  (src_valid[s]),
      .src_beat   (src_beat[s]),
      .conn_mask  (conn_mask[s]),
      .accept     (acc_src[s]),
      .src_ready  (src_ready[s]),
      .req        (req_src[s]),
      .decode_err (decode_err[s])
    );
  end

  // Swap request and accept matrices between the two sides
  for (genvar d = 0; d < N_PORTS; d++) begin : g_xpose_d
    for (genvar s = 0; s < N_PORTS; s++) begin : g_xpose_s
      assign req_dst[d][s] = req_src[s][d];
      assign acc_src[s][d] = acc_dst[d][s];
    end
  end

  for (genvar d = 0; d < N_PORTS; d++) begin : g_dst
    dest_arbiter #(.N_ID(N_ID)) i_dest_arbiter (
      .aclk        (aclk),
      .arst_n      (arst_n),
      .req         (req_dst[d]),
      .beats       (src_beat),
      .slice_ready (slice_ready[d]),
      .accept      (acc_dst[d]),
      .out_valid   (arb_valid[d]),
      .out_beat    (arb_beat[d])
    );

    out_reg_slice i_out_reg_slice (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .in_valid  (arb_valid[d]),
      .in_beat   (arb_beat[d]),
      .in_ready  (slice_ready[d]),
      .out_valid (dst_valid[d]),
      .out_beat  (dst_beat[d]),
      .out_ready (dst_ready[d])
    );
  end

endmodule

`default_nettype wire

// File: hw/out_reg_slice.sv
// Two-entry skid register slice on a destination output
// Registers the beat and the ready toward the arbiter

`timescale 1ns/10ps
`default_nettype none

module out_reg_slice (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  vio_switch_pkg::axis_beat_t  in_beat,
  output logic                        in_ready,
  output logic                        out_valid,
  output vio_switch_pkg::axis_beat_t  out_beat,
  input  logic                        out_ready
);
  import vio_switch_pkg::*;

  logic       main_valid_q;
  logic       skid_valid_q;
  axis_beat_t main_q;
  axis_beat_t skid_q;
  logic       main_load;
  logic       skid_load;
  logic       skid_drain;

  // Ready only drops once the skid entry holds a beat
  assign in_ready  = !skid_valid_q;
  assign out_valid = main_valid_q;
  assign out_beat  = main_q;

  assign main_load  = !skid_valid_q && (!main_valid_q || out_ready);
  assign skid_load  = !skid_valid_q && main_valid_q && !out_ready && in_valid;
  assign skid_drain = skid_valid_q && out_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid_q <= in_valid;
      end
      if (skid_load) begin
        skid_valid_q <= 1'b1;
      end else if (skid_drain) begin
        skid_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      main_q <= in_beat;
    end else if (skid_drain) begin
      main_q <= skid_q;
    end
    if (skid_load) begin
      skid_q <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: hw/dest_arbiter.sv
// Round-robin arbiter for one destination
// Grant is locked from the first beat until the last beat of a packet

`timescale 1ns/10ps
`default_nettype none

module dest_arbiter #(
  parameter int N_ID = 3,
  localparam int N_PORTS = N_ID + vio_switch_pkg::N_SERVICE,
  localparam int PORT_W = $clog2(N_PORTS)
) (
  input  logic                                      aclk,
  input  logic                                      arst_n,
  input  logic [N_PORTS-1:0]                        req,
  input  vio_switch_pkg::axis_beat_t [N_PORTS-1:0]  beats,
  input  logic                                      slice_ready,
  output logic [N_PORTS-1:0]                        accept,
  output logic                                      out_valid,
  output vio_switch_pkg::axis_beat_t                out_beat
);
  import vio_switch_pkg::*;

  arb_state_t        state_q;
  logic [PORT_W-1:0] grant_q;
  logic [PORT_W-1:0] ptr_q;
  logic [PORT_W-1:0] winner;
  logic [PORT_W-1:0] sel;
  logic [PORT_W-1:0] next_ptr;
  logic              xfer;

  // Search from the pointer upward, wrapping at the last port
  // Walk the offsets downward so the nearest requester is kept
  always_comb begin
    int idx;
    winner = ptr_q;
    for (int off = N_PORTS - 1; off >= 0; off--) begin
      idx = int'(ptr_q) + off;
      if (idx >= N_PORTS) begin
        idx = idx - N_PORTS;
      end
      if (req[idx]) begin
        winner = PORT_W'(idx);
      end
    end
  end

  assign sel       = (state_q == ARB_LOCKED) ? grant_q : winner;
  assign out_valid = req[sel];
  assign out_beat  = beats[sel];
  assign xfer      = out_valid && slice_ready;

  always_comb begin
    for (int s = 0; s < N_PORTS; s++) begin
      accept[s] = xfer && (sel == PORT_W'(s));
    end
  end

  assign next_ptr = (sel == PORT_W'(N_PORTS - 1)) ? '0 : sel + 1'b1;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      ptr_q   <= '0;
    end else if (xfer) begin
      if (out_beat.last) begin
        // Packet done, next search starts past this source
        state_q <= ARB_IDLE;
        ptr_q   <= next_ptr;
      end else begin
        state_q <= ARB_LOCKED;
        grant_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/route_decoder.sv
// Per-source tdest decoder
// Raises one request per forwarded beat, swallows packets with a bad
// or disabled destination and flags them on the first beat

`timescale 1ns/10ps
`default_nettype none

module route_decoder #(
  parameter int N_ID = 3,
  localparam int N_PORTS = N_ID + vio_switch_pkg::N_SERVICE
) (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic                        src_valid,
  input  vio_switch_pkg::axis_beat_t  src_beat,
  input  logic [N_PORTS-1:0]          conn_mask,
  input  logic [N_PORTS-1:0]          accept,
  output logic                        src_ready,
  output logic [N_PORTS-1:0]          req,
  output logic                        decode_err
);
  import vio_switch_pkg::*;

  logic               in_pkt_q;
  logic               drop_q;
  logic [N_PORTS-1:0] hit;
  logic               dest_ok;
  logic               drop;
  logic               xfer;

  // One-hot match of tdest, all zero when it names no port
  always_comb begin
    for (int d = 0; d < N_PORTS; d++) begin
      hit[d] = (src_beat.dest == dest_t'(d));
    end
  end

  assign dest_ok = |(hit & conn_mask);

  // Decision is taken on the first beat and held for the whole packet
  assign drop = in_pkt_q ? drop_q : !dest_ok;

  assign req        = (src_valid && !drop) ? hit : '0;
  assign src_ready  = drop || (|accept);
  assign decode_err = src_valid && !in_pkt_q && !dest_ok;
  assign xfer       = src_valid && src_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_pkt_q <= 1'b0;
      drop_q   <= 1'b0;
    end else if (xfer) begin
      in_pkt_q <= !src_beat.last;
      drop_q   <= drop;
    end
  end

endmodule

`default_nettype wire

// File: hw/switch_cfg_regs.sv
// Connectivity matrix of the switch
// One destination mask per source, written through a strobe

`timescale 1ns/10ps
`default_nettype none

module switch_cfg_regs #(
  parameter int N_ID = 3,
  localparam int N_PORTS = N_ID + vio_switch_pkg::N_SERVICE,
  localparam int PORT_W = $clog2(N_PORTS)
) (
  input  logic                             aclk,
  input  logic                             arst_n,
  input  logic                             cfg_wr,
  input  logic [PORT_W-1:0]                cfg_src,
  input  logic [N_PORTS-1:0]               cfg_mask,
  output logic [N_PORTS-1:0][N_PORTS-1:0]  conn_mask
);

  logic [N_PORTS-1:0] wr_sel;

  // Decode the source select, indices past the last port hit nothing
  always_comb begin
    for (int s = 0; s < N_PORTS; s++) begin
      wr_sel[s] = cfg_wr && (cfg_src == PORT_W'(s));
    end
  end

  // Every source may reach every destination after reset
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      conn_mask <= '1;
    end else begin
      for (int s = 0; s < N_PORTS; s++) begin
        if (wr_sel[s]) begin
          conn_mask[s] <= cfg_mask;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/vio_switch_pkg.sv
// Shared widths, port roles, stream beat struct and arbiter states
// for the region and service packet switch

`default_nettype none

package vio_switch_pkg;

  // Stream widths
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8;
  localparam int PID_BITS  = 6;
  localparam int DEST_BITS = 14;

  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [KEEP_BITS-1:0] keep_t;
  typedef logic [PID_BITS-1:0]  pid_t;
  typedef logic [DEST_BITS-1:0] dest_t;

  // Service ports sit right after the N_ID region ports
  localparam int N_SERVICE    = 4;
  localparam int PORT_HOST_TX = 0;
  localparam int PORT_HOST_RX = 1;
  localparam int PORT_RDMA_RX = 2;
  localparam int PORT_TCP     = 3;

  // One beat of a stream, handshake kept outside
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
    pid_t  id;
    dest_t dest;
  } axis_beat_t;

  // Per-destination arbiter FSM
  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_t;

endpackage

`default_nettype wire
